// ==== tb.f ====
+incdir+common
common/sv32_pkg.sv
tlb/sv32_tlb.sv
walker/pte_decode.sv
walker/sv32_walker.sv
design/mmu_top.sv
sim/mmu_checker.sv
sim/tb_mmu.sv

// ==== Makefile ====
TOP := tb_mmu

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== sim/tb_mmu.sv ====
`timescale 1ns/10ps
`include "mmu_config.svh"

module tb_mmu;

    localparam logic [31:0] SEED       = 32'h7022_1f36;
    localparam logic [21:0] ROOT_PPN   = 22'h00100;
    localparam logic [21:0] L2_PPN     = 22'h00101;
    localparam int          WAIT_LIMIT = 200;     // Cycles per request

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] vaddr;
    logic        is_write;
    logic        is_execute;
    logic [1:0]  priv;
    logic        paging_en;
    logic [21:0] satp_ppn;
    logic        flush_all;
    logic [31:0] paddr;
    logic        done;
    logic        page_fault;
    logic [3:0]  fault_cause;
    logic [31:0] ptw_addr;
    logic        ptw_req;
    logic [31:0] ptw_data;
    logic        ptw_ack;
    // Expected result for the checker
    int          test_id;
    logic [31:0] exp_paddr;
    logic        exp_fault;
    logic [3:0]  exp_cause;
    int          exp_timing;
    int          test_count;
    int          err_count;
    logic [31:0] rng_state;
    logic [31:0] root_tbl [8];      // Low part of the root table
    logic [31:0] l2_tbl [16];       // Low part of the only level-2 table

    mmu_top uut (
        .clk              (clk),
        .rst              (rst),
        .translate_req_i  (req),
        .vaddr_i          (vaddr),
        .is_write_i       (is_write),
        .is_execute_i     (is_execute),
        .priv_i           (priv),
        .paging_en_i      (paging_en),
        .satp_ppn_i       (satp_ppn),
        .flush_all_i      (flush_all),
        .paddr_o          (paddr),
        .translate_done_o (done),
        .page_fault_o     (page_fault),
        .fault_cause_o    (fault_cause),
        .ptw_addr_o       (ptw_addr),
        .ptw_req_o        (ptw_req),
        .ptw_data_i       (ptw_data),
        .ptw_ack_i        (ptw_ack)
    );

    mmu_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .translate_req_i (req),
        .vaddr_i         (vaddr),
        .ptw_req_i       (ptw_req),
        .done_i          (done),
        .paddr_i         (paddr),
        .fault_i         (page_fault),
        .cause_i         (fault_cause),
        .test_id_i       (test_id),
        .exp_paddr_i     (exp_paddr),
        .exp_fault_i     (exp_fault),
        .exp_cause_i     (exp_cause),
        .exp_timing_i    (exp_timing),
        .test_count_o    (test_count),
        .err_count_o     (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Page-table memory, anything outside the two tables reads as zero
    function automatic logic [31:0] pt_read(input logic [31:0] addr);
        if (addr[31:12] == ROOT_PPN[19:0] && addr[11:5] == '0)
            return root_tbl[addr[4:2]];
        if (addr[31:12] == L2_PPN[19:0] && addr[11:6] == '0)
            return l2_tbl[addr[5:2]];
        return '0;
    endfunction

    function automatic logic [6:0] leaf_perm(input logic [31:0] r);
        logic [6:0] p;
        p = r[6:0];                     // D A G U X W R
        if (p[2:0] == 3'b000)
            p[0] = 1'b1;                // Keep it a leaf
        return p;
    endfunction

    // Sv32 leaf rules for U and S mode, no SUM and no MXR
    function automatic logic leaf_permits(input logic [31:0] pte, input logic [1:0] pv,
                                          input logic wr, input logic ex);
        if (pte[2] && !pte[1])
            return 1'b0;                // W without R
        if (pv == `MMU_PRIV_U && !pte[4])
            return 1'b0;
        if (pv == `MMU_PRIV_S && pte[4] && ex)
            return 1'b0;
        if (ex)
            return pte[3];
        if (wr)
            return pte[2];
        return pte[1];
    endfunction

    task automatic reference_translate(input logic [31:0] va, input logic wr, input logic ex,
                                       input logic [1:0] pv, output logic [31:0] pa,
                                       output logic flt, output logic [3:0] cause,
                                       output logic is_super);
        logic [31:0] pte1;
        logic [31:0] pte2;
        pa       = '0;
        flt      = 1'b0;
        is_super = 1'b0;
        cause    = ex ? `MMU_FAULT_INST : (wr ? `MMU_FAULT_STORE : `MMU_FAULT_LOAD);
        pte1     = pt_read({ROOT_PPN[19:0], va[31:22], 2'b00});
        if (!pte1[0])
            flt = 1'b1;
        else if (pte1[3:1] != 3'b000) begin
            is_super = 1'b1;            // 4 MiB leaf, PPN[0] must be zero
            if (pte1[19:10] != '0 || !leaf_permits(pte1, pv, wr, ex))
                flt = 1'b1;
            else
                pa = {pte1[29:20], va[21:0]};
        end else begin
            pte2 = pt_read({pte1[29:10], va[21:12], 2'b00});
            if (!pte2[0] || pte2[3:1] == 3'b000 || !leaf_permits(pte2, pv, wr, ex))
                flt = 1'b1;
            else
                pa = {pte2[29:10], va[11:0]};
        end
    endtask

    task automatic fill_tables();
        logic [31:0] r;
        logic [31:0] p;
        logic [6:0]  perm;
        root_tbl[0] = {L2_PPN, 10'h001};    // Pointers to the level-2 table
        root_tbl[1] = {L2_PPN, 10'h001};
        for (int i = 2; i < 8; i++) begin
            r    = next_rand();
            p    = next_rand();
            perm = leaf_perm(r);
            case (r[9:8])
                2'd0:    root_tbl[i] = {r[31:1], 1'b0};                           // Invalid
                2'd2:    root_tbl[i] = {p[11:0], p[21:12] | 10'd1, 2'b00, perm, 1'b1};
                default: root_tbl[i] = {p[11:0], 10'd0, 2'b00, perm, 1'b1};       // Superpage
            endcase
        end
        for (int i = 0; i < 16; i++) begin
            r    = next_rand();
            p    = next_rand();
            perm = leaf_perm(r);
            case (r[10:8])
                3'd0:    l2_tbl[i] = {r[31:1], 1'b0};
                3'd1:    l2_tbl[i] = {p[21:0], 10'h001};    // Pointer at level 2
                default: l2_tbl[i] = {p[21:0], 2'b00, perm, 1'b1};
            endcase
        end
    endtask

    function automatic logic [31:0] random_vaddr();
        logic [31:0] r;
        logic [9:0]  vpn1;
        logic [9:0]  vpn0;
        r    = next_rand();
        vpn1 = 10'(r[3:0] % 4'd10);     // 8 and 9 lie past the filled root entries
        vpn0 = 10'(r[9:4] % 6'd20);
        return {vpn1, vpn0, r[27:16]};
    endfunction

    task automatic flush_tlb();
        @(posedge clk);
        #1;
        flush_all = 1'b1;
        @(posedge clk);
        #1;
        flush_all = 1'b0;
    endtask

    // Negative id picks the walk name from the model result
    task automatic issue(input int id, input logic [31:0] va, input logic wr,
                         input logic ex, input logic [1:0] pv, input logic pg,
                         input int timing);
        logic [31:0] pa;
        logic        flt;
        logic [3:0]  cause;
        logic        is_super;
        int          cycles;
        if (pg)
            reference_translate(va, wr, ex, pv, pa, flt, cause, is_super);
        else begin
            pa       = va;              // Bare mode
            flt      = 1'b0;
            cause    = '0;
            is_super = 1'b0;
        end
        @(posedge clk);
        #1;
        test_id    = (id >= 0) ? id : (flt ? 3 : (is_super ? 2 : 1));
        exp_paddr  = pa;
        exp_fault  = flt;
        exp_cause  = cause;
        exp_timing = timing;
        paging_en  = pg;
        vaddr      = va;
        is_write   = wr;
        is_execute = ex;
        priv       = pv;
        req        = 1'b1;
        cycles     = 0;
        @(negedge clk);
        while (!done && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk);
        end
        if (!done) begin
            $display("timeout: no translate_done_o within %0d cycles for vaddr %h",
                     WAIT_LIMIT, va);
            $display("Testbench failed");
            $finish;
        end else begin
            @(posedge clk);
            #1;
            req = 1'b0;
        end
    endtask

    // Memory answers 0 to 5 cycles after it first sees a request
    initial begin : pt_memory
        logic [31:0] mem_addr;
        logic [31:0] mem_rng;
        logic        pending;
        int          delay;
        ptw_ack  = 1'b0;
        ptw_data = '0;
        mem_addr = '0;
        mem_rng  = SEED;
        pending  = 1'b0;
        delay    = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ptw_ack)
                ptw_ack = 1'b0;         // One-cycle ack
            else if (pending) begin
                if (delay == 0) begin
                    ptw_data = pt_read(mem_addr);
                    ptw_ack  = 1'b1;
                    pending  = 1'b0;
                end else
                    delay--;
            end
            @(negedge clk);
            if (!rst && ptw_req && !pending && !ptw_ack) begin
                mem_rng  = xorshift32(mem_rng);
                delay    = int'(mem_rng % 32'd6);
                mem_addr = ptw_addr;
                pending  = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] va;
        logic [31:0] r;
        logic [31:0] pa;
        logic        flt;
        logic [3:0]  cause;
        logic        is_super;
        logic        wr;
        logic        ex;
        logic [1:0]  pv;
        logic        rwr;
        logic        rex;
        logic [1:0]  rpv;
        logic        found;
        rng_state  = SEED;
        rst        = 1'b1;
        req        = 1'b0;
        vaddr      = '0;
        is_write   = 1'b0;
        is_execute = 1'b0;
        priv       = `MMU_PRIV_S;
        paging_en  = 1'b0;
        satp_ppn   = ROOT_PPN;
        flush_all  = 1'b0;
        test_id    = 0;
        exp_paddr  = '0;
        exp_fault  = 1'b0;
        exp_cause  = '0;
        exp_timing = 0;
        fill_tables();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int n = 0; n < 16; n++)
            issue(0, next_rand(), 1'b0, 1'b0, `MMU_PRIV_S, 1'b0, 1);

        // Walk from a flushed TLB, hit, refused hit, walk again after flush
        for (int n = 0; n < 40; n++) begin
            va = random_vaddr();
            r  = next_rand();
            wr = (r[1:0] % 2'd3 == 2'd1);
            ex = (r[1:0] % 2'd3 == 2'd2);
            pv = r[8] ? `MMU_PRIV_U : `MMU_PRIV_S;
            flush_tlb();
            issue(-1, va, wr, ex, pv, 1'b1, 2);
            reference_translate(va, wr, ex, pv, pa, flt, cause, is_super);
            if (!flt) begin
                issue(4, va, wr, ex, pv, 1'b1, 1);
                found = 1'b0;
                rwr   = 1'b0;
                rex   = 1'b0;
                rpv   = `MMU_PRIV_U;
                for (int k = 0; k < 6; k++) begin
                    if (!found) begin
                        rwr = (k % 3 == 1);
                        rex = (k % 3 == 2);
                        rpv = (k < 3) ? `MMU_PRIV_U : `MMU_PRIV_S;
                        reference_translate(va, rwr, rex, rpv, pa, flt, cause, is_super);
                        found = flt;
                    end
                end
                if (found)
                    issue(5, va, rwr, rex, rpv, 1'b1, 1);
                flush_tlb();
                issue(6, va, wr, ex, pv, 1'b1, 2);
            end
        end

        // TLB filling up and wrapping, hits and misses mixed
        for (int n = 0; n < 60; n++) begin
            va = random_vaddr();
            r  = next_rand();
            issue(7, va, r[0] & ~r[1], r[1], r[8] ? `MMU_PRIV_U : `MMU_PRIV_S, 1'b1, 0);
        end

        repeat (4) @(posedge clk);
        $display("tests run %0d, failed %0d", test_count, err_count);
        if (err_count == 0 && test_count > 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sim/mmu_checker.sv ====
`timescale 1ns/10ps
`include "mmu_config.svh"

module mmu_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        translate_req_i,
    input  logic [31:0] vaddr_i,
    input  logic        ptw_req_i,
    input  logic        done_i,
    input  logic [31:0] paddr_i,
    input  logic        fault_i,
    input  logic [3:0]  cause_i,
    input  int          test_id_i,
    input  logic [31:0] exp_paddr_i,
    input  logic        exp_fault_i,
    input  logic [3:0]  exp_cause_i,
    input  int          exp_timing_i,     // 0 any, 1 same cycle, 2 through a walk
    output int          test_count_o,
    output int          err_count_o
);

    logic active;       // Request seen, done not yet
    logic saw_ptw;      // Page-table read during this request
    int   wait_cycles;

    function automatic string test_name(input int id);
        case (id)
            0: return "bare";
            1: return "walk_4k";
            2: return "walk_super";
            3: return "walk_fault";
            4: return "tlb_hit";
            5: return "tlb_refused";
            6: return "after_flush";
            7: return "mixed";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_result();
        string name;
        name = test_name(test_id_i);
        test_count_o++;
        err_count_o++;                  // Taken back below when all is right
        if (fault_i !== exp_fault_i)
            $display("mismatch %s #%0d fault expected %0d actual %0d",
                     name, test_count_o, exp_fault_i, fault_i);
        else if (exp_fault_i && cause_i !== exp_cause_i)
            $display("mismatch %s #%0d cause expected %0d actual %0d",
                     name, test_count_o, exp_cause_i, cause_i);
        else if (!exp_fault_i && paddr_i !== exp_paddr_i)
            $display("mismatch %s #%0d paddr expected %h actual %h",
                     name, test_count_o, exp_paddr_i, paddr_i);
        else if (exp_timing_i == 1 && (wait_cycles != 0 || saw_ptw))
            $display("%s #%0d: answer took %0d extra cycles or read page tables",
                     name, test_count_o, wait_cycles);
        else if (exp_timing_i == 2 && !saw_ptw)
            $display("%s #%0d: done came without any page-table read", name, test_count_o);
        else begin
            err_count_o--;
            $display("ok %s #%0d vaddr %h paddr %h fault %0d cause %0d",
                     name, test_count_o, vaddr_i, paddr_i, fault_i, cause_i);
        end
    endtask

    // Mid-cycle sampling, all outputs settled
    always @(negedge clk) begin
        if (rst) begin
            active       = 1'b0;
            saw_ptw      = 1'b0;
            wait_cycles  = 0;
            test_count_o = 0;
            err_count_o  = 0;
        end else if (done_i && !translate_req_i) begin
            $display("done pulse seen while no request was pending");
            err_count_o++;
        end else if (translate_req_i) begin
            if (!active) begin
                active      = 1'b1;     // First cycle of a new request
                wait_cycles = 0;
                saw_ptw     = 1'b0;
            end else
                wait_cycles++;
            if (ptw_req_i)
                saw_ptw = 1'b1;
            if (done_i) begin
                check_result();
                active = 1'b0;
            end
        end
    end

endmodule

// ==== design/mmu_top.sv ====
`timescale 1ns/10ps

module mmu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   translate_req_i,
    input  sv32_pkg::vaddr_t       vaddr_i,
    input  logic                   is_write_i,
    input  logic                   is_execute_i,
    input  sv32_pkg::priv_t        priv_i,
    input  logic                   paging_en_i,
    input  sv32_pkg::ppn_t         satp_ppn_i,     // Root table PPN
    input  logic                   flush_all_i,
    output sv32_pkg::paddr_t       paddr_o,
    output logic                   translate_done_o,
    output logic                   page_fault_o,
    output sv32_pkg::fault_cause_t fault_cause_o,
    output sv32_pkg::paddr_t       ptw_addr_o,
    output logic                   ptw_req_o,
    input  sv32_pkg::pte_t         ptw_data_i,
    input  logic                   ptw_ack_i
);

    // Walker to TLB
    logic           lookup_en;
    sv32_pkg::vpn_t lookup_vpn;
    logic           fill;
    sv32_pkg::vpn_t fill_vpn;
    sv32_pkg::ppn_t fill_ppn;
    sv32_pkg::perm_t fill_perm;
    logic           fill_super;
    // TLB to walker
    logic            hit;
    sv32_pkg::ppn_t  hit_ppn;
    sv32_pkg::perm_t hit_perm;
    logic            hit_super;
    // PTE decoder hookup
    sv32_pkg::pte_t  dec_pte;
    logic            dec_level1;
    sv32_pkg::priv_t dec_priv;
    logic            dec_is_write;
    logic            dec_is_execute;
    logic            dec_pointer;
    logic            dec_leaf_ok;
    logic            dec_fault;

    sv32_tlb u_tlb (
        .clk          (clk),
        .rst          (rst),
        .lookup_en_i  (lookup_en),
        .lookup_vpn_i (lookup_vpn),
        .hit_o        (hit),
        .hit_ppn_o    (hit_ppn),
        .hit_perm_o   (hit_perm),
        .hit_super_o  (hit_super),
        .fill_i       (fill),
        .fill_vpn_i   (fill_vpn),
        .fill_ppn_i   (fill_ppn),
        .fill_perm_i  (fill_perm),
        .fill_super_i (fill_super),
        .flush_all_i  (flush_all_i)
    );

    sv32_walker u_walker (
        .clk              (clk),
        .rst              (rst),
        .translate_req_i  (translate_req_i),
        .vaddr_i          (vaddr_i),
        .is_write_i       (is_write_i),
        .is_execute_i     (is_execute_i),
        .priv_i           (priv_i),
        .paging_en_i      (paging_en_i),
        .satp_ppn_i       (satp_ppn_i),
        .paddr_o          (paddr_o),
        .translate_done_o (translate_done_o),
        .page_fault_o     (page_fault_o),
        .fault_cause_o    (fault_cause_o),
        .ptw_addr_o       (ptw_addr_o),
        .ptw_req_o        (ptw_req_o),
        .ptw_data_i       (ptw_data_i),
        .ptw_ack_i        (ptw_ack_i),
        .lookup_en_o      (lookup_en),
        .lookup_vpn_o     (lookup_vpn),
        .hit_i            (hit),
        .hit_ppn_i        (hit_ppn),
        .hit_perm_i       (hit_perm),
        .hit_super_i      (hit_super),
        .fill_o           (fill),
        .fill_vpn_o       (fill_vpn),
        .fill_ppn_o       (fill_ppn),
        .fill_perm_o      (fill_perm),
        .fill_super_o     (fill_super),
        .pte_o            (dec_pte),
        .level1_o         (dec_level1),
        .dec_priv_o       (dec_priv),
        .dec_is_write_o   (dec_is_write),
        .dec_is_execute_o (dec_is_execute),
        .is_pointer_i     (dec_pointer),
        .leaf_ok_i        (dec_leaf_ok),
        .pte_fault_i      (dec_fault)
    );

    pte_decode u_pte_decode (
        .pte_i        (dec_pte),
        .level1_i     (dec_level1),
        .priv_i       (dec_priv),
        .is_write_i   (dec_is_write),
        .is_execute_i (dec_is_execute),
        .is_pointer_o (dec_pointer),
        .leaf_ok_o    (dec_leaf_ok),
        .fault_o      (dec_fault)
    );

endmodule

// ==== walker/sv32_walker.sv ====
`timescale 1ns/10ps
`include "mmu_config.svh"

module sv32_walker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   translate_req_i,
    input  sv32_pkg::vaddr_t       vaddr_i,
    input  logic                   is_write_i,
    input  logic                   is_execute_i,
    input  sv32_pkg::priv_t        priv_i,
    input  logic                   paging_en_i,
    input  sv32_pkg::ppn_t         satp_ppn_i,
    output sv32_pkg::paddr_t       paddr_o,
    output logic                   translate_done_o,
    output logic                   page_fault_o,
    output sv32_pkg::fault_cause_t fault_cause_o,
    output sv32_pkg::paddr_t       ptw_addr_o,
    output logic                   ptw_req_o,
    input  sv32_pkg::pte_t         ptw_data_i,
    input  logic                   ptw_ack_i,
    output logic                   lookup_en_o,
    output sv32_pkg::vpn_t         lookup_vpn_o,
    input  logic                   hit_i,
    input  sv32_pkg::ppn_t         hit_ppn_i,
    input  sv32_pkg::perm_t        hit_perm_i,
    input  logic                   hit_super_i,
    output logic                   fill_o,
    output sv32_pkg::vpn_t         fill_vpn_o,
    output sv32_pkg::ppn_t         fill_ppn_o,
    output sv32_pkg::perm_t        fill_perm_o,
    output logic                   fill_super_o,
    output sv32_pkg::pte_t         pte_o,
    output logic                   level1_o,
    output sv32_pkg::priv_t        dec_priv_o,
    output logic                   dec_is_write_o,
    output logic                   dec_is_execute_o,
    input  logic                   is_pointer_i,
    input  logic                   leaf_ok_i,
    input  logic                   pte_fault_i
);

    sv32_pkg::walk_state_t state, next_state;
    sv32_pkg::vaddr_t      saved_vaddr;     // Request latched on a miss
    logic                  saved_write;
    logic                  saved_exec;
    sv32_pkg::priv_t       saved_priv;
    sv32_pkg::ppn_t        l2_ppn;          // From the level-1 pointer
    logic                  miss;
    logic                  hit_ok;

    function automatic sv32_pkg::fault_cause_t cause_of(input logic wr, input logic ex);
        if (ex) return `MMU_FAULT_INST;
        if (wr) return `MMU_FAULT_STORE;
        return `MMU_FAULT_LOAD;
    endfunction

    assign lookup_en_o  = (state == sv32_pkg::IDLE) && translate_req_i && paging_en_i;
    assign lookup_vpn_o = vaddr_i[31:12];
    assign miss   = lookup_en_o && !hit_i;
    assign hit_ok = sv32_pkg::perm_allows(hit_perm_i, priv_i, is_write_i, is_execute_i);

    // Decoder always judges the live memory word against the latched access
    assign pte_o            = ptw_data_i;
    assign level1_o         = (state == sv32_pkg::L1_WAIT);
    assign dec_priv_o       = saved_priv;
    assign dec_is_write_o   = saved_write;
    assign dec_is_execute_o = saved_exec;

    // Refill payload straight from the leaf PTE
    assign fill_vpn_o   = saved_vaddr[31:12];
    assign fill_ppn_o   = ptw_data_i[31:10];
    assign fill_perm_o  = ptw_data_i[4:1];
    assign fill_super_o = level1_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= sv32_pkg::IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            saved_vaddr <= vaddr_i;
            saved_write <= is_write_i;
            saved_exec  <= is_execute_i;
            saved_priv  <= priv_i;
        end
        if (level1_o && ptw_ack_i && is_pointer_i)
            l2_ppn <= ptw_data_i[31:10];
    end

    always_comb begin
        next_state       = state;
        paddr_o          = '0;
        translate_done_o = 1'b0;
        page_fault_o     = 1'b0;
        fault_cause_o    = '0;
        ptw_addr_o       = '0;
        ptw_req_o        = 1'b0;
        fill_o           = 1'b0;
        case (state)
            sv32_pkg::IDLE: begin
                if (translate_req_i && !paging_en_i) begin
                    paddr_o          = vaddr_i;     // Bare mode
                    translate_done_o = 1'b1;
                end else if (lookup_en_o && hit_i) begin
                    translate_done_o = 1'b1;
                    if (!hit_ok) begin
                        page_fault_o  = 1'b1;
                        fault_cause_o = cause_of(is_write_i, is_execute_i);
                    end else if (hit_super_i)
                        paddr_o = {hit_ppn_i[19:10], vaddr_i[21:0]};
                    else
                        paddr_o = {hit_ppn_i[19:0], vaddr_i[11:0]};
                end else if (miss) begin
                    ptw_addr_o = {satp_ppn_i[19:0], vaddr_i[31:22], 2'b00};
                    ptw_req_o  = 1'b1;
                    next_state = sv32_pkg::L1_WAIT;
                end
            end
            sv32_pkg::L1_WAIT: begin
                ptw_addr_o = {satp_ppn_i[19:0], saved_vaddr[31:22], 2'b00};
                ptw_req_o  = !ptw_ack_i;    // Drops in the ack cycle
                if (ptw_ack_i) begin
                    if (is_pointer_i)
                        next_state = sv32_pkg::L2_WAIT;
                    else if (leaf_ok_i) begin
                        paddr_o          = {ptw_data_i[29:20], saved_vaddr[21:0]};
                        translate_done_o = 1'b1;
                        fill_o           = 1'b1;
                        next_state       = sv32_pkg::IDLE;
                    end else if (pte_fault_i)
                        next_state = sv32_pkg::FAULT;
                end
            end
            sv32_pkg::L2_WAIT: begin
                ptw_addr_o = {l2_ppn[19:0], saved_vaddr[21:12], 2'b00};
                ptw_req_o  = !ptw_ack_i;
                if (ptw_ack_i) begin
                    if (leaf_ok_i) begin
                        paddr_o          = {ptw_data_i[29:10], saved_vaddr[11:0]};
                        translate_done_o = 1'b1;
                        fill_o           = 1'b1;
                        next_state       = sv32_pkg::IDLE;
                    end else if (pte_fault_i)
                        next_state = sv32_pkg::FAULT;
                end
            end
            sv32_pkg::FAULT: begin
                translate_done_o = 1'b1;
                page_fault_o     = 1'b1;
                fault_cause_o    = cause_of(saved_write, saved_exec);
                next_state       = sv32_pkg::IDLE;
            end
            default: next_state = sv32_pkg::IDLE;
        endcase
    end

    a_done_xor_req: assert property (@(posedge clk) disable iff (rst)
        !(translate_done_o && ptw_req_o));

    // Memory sees one stable address per outstanding read
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        ptw_req_o && !ptw_ack_i |=> (ptw_req_o || ptw_ack_i) && $stable(ptw_addr_o));

endmodule

// ==== walker/pte_decode.sv ====
`timescale 1ns/10ps

module pte_decode (
    input  sv32_pkg::pte_t  pte_i,
    input  logic            level1_i,     // PTE came from the root table
    input  sv32_pkg::priv_t priv_i,
    input  logic            is_write_i,
    input  logic            is_execute_i,
    output logic            is_pointer_o,
    output logic            leaf_ok_o,
    output logic            fault_o
);

    logic            valid;
    logic            leaf;
    logic            misaligned;
    logic            allowed;
    sv32_pkg::perm_t perm;

    assign valid = pte_i[0];
    // Any of R, W, X makes a leaf; W alone is then refused by the permission check
    assign leaf  = pte_i[1] | pte_i[2] | pte_i[3];
    assign perm  = pte_i[4:1];                      // U X W R

    // 4 MiB leaf needs PPN[0] clear
    assign misaligned = level1_i && (pte_i[19:10] != '0);

    assign allowed = sv32_pkg::perm_allows(perm, priv_i, is_write_i, is_execute_i);

    assign is_pointer_o = valid && !leaf && level1_i;
    assign leaf_ok_o    = valid && leaf && !misaligned && allowed;

    // Invalid, pointer at level 2, misaligned superpage or refused
    always_comb begin
        fault_o = 1'b0;
        if (!valid)
            fault_o = 1'b1;
        else if (!leaf && !level1_i)
            fault_o = 1'b1;
        else if (leaf && misaligned)
            fault_o = 1'b1;
        else if (leaf && !allowed)
            fault_o = 1'b1;
    end

endmodule

// ==== tlb/sv32_tlb.sv ====
`timescale 1ns/10ps
`include "mmu_config.svh"

module sv32_tlb (
    input  logic            clk,
    input  logic            rst,
    input  logic            lookup_en_i,
    input  sv32_pkg::vpn_t  lookup_vpn_i,
    output logic            hit_o,
    output sv32_pkg::ppn_t  hit_ppn_o,
    output sv32_pkg::perm_t hit_perm_o,
    output logic            hit_super_o,
    input  logic            fill_i,
    input  sv32_pkg::vpn_t  fill_vpn_i,
    input  sv32_pkg::ppn_t  fill_ppn_i,
    input  sv32_pkg::perm_t fill_perm_i,
    input  logic            fill_super_i,
    input  logic            flush_all_i
);

    localparam int N     = `MMU_TLB_ENTRIES;
    localparam int IDX_W = $clog2(N);

    logic [N-1:0]    valid;
    sv32_pkg::vpn_t  tag_vpn [N];
    sv32_pkg::ppn_t  ent_ppn [N];
    sv32_pkg::perm_t ent_perm [N];
    logic [N-1:0]    ent_super;
    logic [IDX_W-1:0] rr_ptr;       // Next victim
    logic [N-1:0]    match;

    // Superpage compares VPN[1] only
    always_comb begin
        for (int i = 0; i < N; i++) begin
            match[i] = valid[i]
                && tag_vpn[i][2*`MMU_VPN_W-1:`MMU_VPN_W]
                   == lookup_vpn_i[2*`MMU_VPN_W-1:`MMU_VPN_W]
                && (ent_super[i]
                    || tag_vpn[i][`MMU_VPN_W-1:0] == lookup_vpn_i[`MMU_VPN_W-1:0]);
        end
    end

    // OR mux, at most one entry matches
    always_comb begin
        hit_o       = 1'b0;
        hit_ppn_o   = '0;
        hit_perm_o  = '0;
        hit_super_o = 1'b0;
        if (lookup_en_i) begin
            for (int i = 0; i < N; i++) begin
                if (match[i]) begin
                    hit_o       = 1'b1;
                    hit_ppn_o   = hit_ppn_o | ent_ppn[i];
                    hit_perm_o  = hit_perm_o | ent_perm[i];
                    hit_super_o = hit_super_o | ent_super[i];
                end
            end
        end
    end

    // Valid bits and victim pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else begin
            if (fill_i) begin
                valid[rr_ptr] <= 1'b1;
                rr_ptr <= (rr_ptr == IDX_W'(N - 1)) ? '0 : rr_ptr + 1'b1;
            end
            if (flush_all_i)
                valid <= '0;    // Flush wins over a same cycle refill
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_vpn[rr_ptr]   <= fill_vpn_i;
            ent_ppn[rr_ptr]   <= fill_ppn_i;
            ent_perm[rr_ptr]  <= fill_perm_i;
            ent_super[rr_ptr] <= fill_super_i;
        end
    end

    // Walks start only on a miss, so refills never duplicate a mapping
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        lookup_en_i |-> $onehot0(match));

endmodule

// ==== common/sv32_pkg.sv ====
`include "mmu_config.svh"

package sv32_pkg;

    typedef logic [`MMU_XLEN-1:0]      vaddr_t;
    typedef logic [`MMU_XLEN-1:0]      paddr_t;
    typedef logic [`MMU_XLEN-1:0]      pte_t;    // V R W X U G A D RSW PPN
    typedef logic [2*`MMU_VPN_W-1:0]   vpn_t;    // {VPN[1], VPN[0]}
    typedef logic [`MMU_PPN_W-1:0]     ppn_t;
    typedef logic [3:0]                perm_t;   // {U, X, W, R}
    typedef logic [1:0]                priv_t;
    typedef logic [3:0]                fault_cause_t;

    typedef enum logic [1:0] {
        IDLE,       // Answers bare mode and TLB hits
        L1_WAIT,    // Root table read outstanding
        L2_WAIT,    // Second level read outstanding
        FAULT       // Report fault one cycle after the bad PTE
    } walk_state_t;

    // Shared by the TLB hit path and the PTE decoder
    function automatic logic perm_allows(
        input perm_t perm,
        input priv_t priv,
        input logic  is_write,
        input logic  is_execute
    );
        logic ok;
        ok = 1'b1;
        if (perm[1] && !perm[0])                          // W without R is reserved
            ok = 1'b0;
        if (priv == `MMU_PRIV_U && !perm[3])              // U mode needs U page
            ok = 1'b0;
        if (priv == `MMU_PRIV_S && perm[3] && is_execute) // No S fetch from U page
            ok = 1'b0;
        if (!is_write && !is_execute && !perm[0]) ok = 1'b0;  // Load
        if (is_write && !perm[1]) ok = 1'b0;                  // Store
        if (is_execute && !perm[2]) ok = 1'b0;                // Fetch
        return ok;
    endfunction

endpackage

// ==== common/mmu_config.svh ====
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Sv32 widths
`define MMU_XLEN        32
`define MMU_VPN_W       10      // One VPN part
`define MMU_PPN_W       22
`define MMU_OFFS_W      12      // 4 KiB page offset

// TLB size
`define MMU_TLB_ENTRIES 8

// Privilege modes as in mstatus.MPP
`define MMU_PRIV_U      2'd0
`define MMU_PRIV_S      2'd1
`define MMU_PRIV_M      2'd3

// Page fault exception codes
`define MMU_FAULT_INST  4'd12
`define MMU_FAULT_LOAD  4'd13
`define MMU_FAULT_STORE 4'd15

`endif
